// ==== filelist.f ====
common/cursor_pkg.sv
cursor/cursor_regs.sv
cursor/cursor_control.sv
hdl/phase_timer.sv
hdl/frame_buffer.sv
hdl/cursor_top.sv
verification/cursor_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cursor_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= TESTBENCH PASSED

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/cursor_tb.sv ====
`default_nettype none

module cursor_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import cursor_pkg::*;

  localparam int reset_cycles = 16;
  localparam int run_timeout  = 400;
  localparam logic [phase_w-1:0] reset_len = 8'd4;

  logic               clk = 1'b0;
  logic               rst;
  logic               cfg_we;
  cfg_addr_e          cfg_addr;
  logic [pixel_w-1:0] cfg_wdata;
  logic               init;
  logic [coord_w-1:0] rd_x;
  logic [coord_w-1:0] rd_y;
  logic [pixel_w-1:0] rd_data;
  logic               cursor_done;

  int   done_errors  = 0;
  int   pixel_errors = 0;
  int   other_errors = 0;
  int   cycle        = 0;
  int   white_reads  = 0;
  logic armed        = 1'b0;

  // register mirror, as the host sees it.
  logic [coord_w-1:0] ref_x;
  logic [coord_w-1:0] ref_y;
  logic [phase_w-1:0] ref_white;
  logic [phase_w-1:0] ref_black;

  // expected run, latched at the init edge.
  logic               busy;
  logic [9:0]         remaining;
  logic [coord_w-1:0] run_x;
  logic [coord_w-1:0] run_y;
  logic [phase_w-1:0] run_white;
  logic [phase_w-1:0] run_black;
  logic               exp_done;

  logic [pixel_w-1:0] shadow [fb_depth];
  logic               known [fb_depth];
  logic [pixel_w-1:0] exp_rd;
  logic               exp_known = 1'b0;
  logic [coord_w-1:0] check_x;
  logic [coord_w-1:0] check_y;

  cursor_top dut (
    .clk         (clk),
    .rst         (rst),
    .cfg_we      (cfg_we),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .init        (init),
    .rd_x        (rd_x),
    .rd_y        (rd_y),
    .rd_data     (rd_data),
    .cursor_done (cursor_done)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    armed <= 1'b1;
  end

  // white lands at k+2, black at k+white+4, done at k+white+black+5.
  always @(posedge clk) begin
    if (rst) begin
      ref_x     <= '0;
      ref_y     <= '0;
      ref_white <= reset_len;
      ref_black <= reset_len;
      busy      <= 1'b0;
      remaining <= '0;
      exp_done  <= 1'b0;
      for (int i = 0; i < fb_depth; i++) begin
        known[i] <= 1'b0;
      end
    end else begin
      if (cfg_we) begin
        case (cfg_addr)
          addr_x:     ref_x <= cfg_wdata[coord_w-1:0];
          addr_y:     ref_y <= cfg_wdata[coord_w-1:0];
          addr_white: ref_white <= cfg_wdata;
          addr_black: ref_black <= cfg_wdata;
        endcase
      end
      exp_done <= 1'b0;
      if (!busy) begin
        if (init) begin
          busy      <= 1'b1;
          remaining <= 10'(ref_white) + 10'(ref_black) + 10'd5;
          run_x     <= ref_x;
          run_y     <= ref_y;
          run_white <= ref_white;
          run_black <= ref_black;
        end
      end else begin
        remaining <= remaining - 10'd1;
        if (remaining == 10'(run_white) + 10'(run_black) + 10'd4) begin
          shadow[{run_y, run_x}] <= white_px;
          known[{run_y, run_x}]  <= 1'b1;
        end
        if (remaining == 10'(run_black) + 10'd2) begin
          shadow[{run_y, run_x}] <= black_px;
          known[{run_y, run_x}]  <= 1'b1;
        end
        if (remaining == 10'd1) begin
          exp_done <= 1'b1;
          busy     <= 1'b0;
        end
      end
    end
  end

  // read port model, old value on a same-cycle write.
  always @(posedge clk) begin
    exp_rd    <= shadow[{rd_y, rd_x}];
    exp_known <= !rst && known[{rd_y, rd_x}];
    check_x   <= rd_x;
    check_y   <= rd_y;
    if (exp_known && exp_rd == white_px) begin
      white_reads <= white_reads + 1;
    end
  end

  done_matches_model: assert property (@(posedge clk) armed |-> cursor_done === exp_done)
    else begin
      done_errors++;
      $display("Fail cursor_done: got %h, expected %h, state %s",
               $sampled(cursor_done), $sampled(exp_done), dut.control.state.name());
    end

  pixel_matches_model: assert property (@(posedge clk) exp_known |-> rd_data === exp_rd)
    else begin
      pixel_errors++;
      $display("Fail rd_data at x %h y %h: got %h, expected %h",
               $sampled(check_x), $sampled(check_y), $sampled(rd_data), $sampled(exp_rd));
    end

  task automatic report_and_finish();
    int total;
    total = done_errors + pixel_errors + other_errors;
    $display("errors: %0d total, %0d cursor_done, %0d rd_data, %0d other",
             total, done_errors, pixel_errors, other_errors);
    if (total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  function automatic logic [7:0] random_in_range();
    return 8'(($urandom % 20) + 1);
  endfunction

  task automatic idle(input int cycles);
    repeat (cycles) @(posedge clk);
    #1;
  endtask

  task automatic write_reg(input cfg_addr_e addr, input logic [7:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
  endtask

  task automatic look_at(input logic [7:0] x, input logic [7:0] y);
    rd_x = x[coord_w-1:0];
    rd_y = y[coord_w-1:0];
  endtask

  task automatic pulse_init();
    init = 1'b1;
    @(posedge clk);
    #1;
    init = 1'b0;
  endtask

  task automatic wait_done(input int limit);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < limit) begin
      @(posedge clk);
      #1;
      waited++;
      seen = cursor_done;
    end
    if (!seen) begin
      other_errors++;
      $display("timeout: cursor_done did not rise within %0d cycles", limit);
      report_and_finish();
    end
  endtask

  task automatic configure(input logic [7:0] wlen, input logic [7:0] blen);
    write_reg(addr_white, wlen);
    write_reg(addr_black, blen);
  endtask

  initial begin
    logic [7:0] x0;
    logic [7:0] y0;
    logic [7:0] wlen;
    logic [7:0] blen;
    int         prev_cycle;
    int         gap;
    int         expected_gap;

    rst       = 1'b1;
    cfg_we    = 1'b0;
    cfg_addr  = addr_x;
    cfg_wdata = '0;
    init      = 1'b0;
    rd_x      = '0;
    rd_y      = '0;
    void'($urandom(32'hea6e_7341));

    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    idle(10);

    // earlier run paints the right-hand neighbor.
    x0   = random_in_range();
    y0   = random_in_range();
    wlen = random_in_range();
    blen = random_in_range();
    write_reg(addr_x, x0 + 8'd1);
    write_reg(addr_y, y0);
    configure(wlen, blen);
    look_at(x0 + 8'd1, y0);
    pulse_init();
    wait_done(run_timeout);
    idle(3);

    // cursor run, watched through the read port.
    write_reg(addr_x, x0);
    look_at(x0, y0);
    pulse_init();
    wait_done(run_timeout);
    idle(3);
    look_at(x0 + 8'd1, y0);
    idle(3);
    look_at(x0, y0);
    idle(3);

    // moving x mid-run must not move the painted pixel.
    wlen = random_in_range();
    blen = random_in_range();
    configure(wlen, blen);
    look_at(x0 + 8'd1, y0);
    pulse_init();
    idle(2);
    write_reg(addr_x, x0 + 8'd1);
    wait_done(run_timeout);
    look_at(x0, y0);
    idle(3);
    look_at(x0 + 8'd1, y0);
    pulse_init();
    wait_done(run_timeout);
    idle(3);

    // init held high.
    wlen = random_in_range();
    blen = random_in_range();
    configure(wlen, blen);
    expected_gap = int'(wlen) + int'(blen) + 6;
    init = 1'b1;
    wait_done(run_timeout);
    prev_cycle = cycle;
    for (int r = 0; r < 2; r++) begin
      wait_done(run_timeout);
      gap        = cycle - prev_cycle;
      prev_cycle = cycle;
      assert (gap == expected_gap)
        else begin
          other_errors++;
          $display("Fail cursor_done period: got %h, expected %h", gap, expected_gap);
        end
    end
    init = 1'b0;
    idle(10);

    if (white_reads == 0) begin
      other_errors++;
      $display("no white pixel was read back during any white phase");
    end
    report_and_finish();
  end

endmodule

`default_nettype wire

// ==== hdl/cursor_top.sv ====
`default_nettype none

module cursor_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           cfg_we,
  input  cursor_pkg::cfg_addr_e          cfg_addr,
  input  logic [cursor_pkg::pixel_w-1:0] cfg_wdata,
  input  logic                           init,
  input  logic [cursor_pkg::coord_w-1:0] rd_x,
  input  logic [cursor_pkg::coord_w-1:0] rd_y,
  output logic [cursor_pkg::pixel_w-1:0] rd_data,
  output logic                           cursor_done
);

  import cursor_pkg::*;

  cursor_cfg_t cfg;
  pixel_wr_t   wr;

  logic count_white;
  logic count_black;
  logic white_done;
  logic black_done;

  cursor_regs regs (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  cursor_control control (
    .clk         (clk),
    .rst         (rst),
    .init        (init),
    .cfg         (cfg),
    .white_done  (white_done),
    .black_done  (black_done),
    .count_white (count_white),
    .count_black (count_black),
    .wr          (wr),
    .cursor_done (cursor_done)
  );

  phase_timer white_timer (
    .clk    (clk),
    .rst    (rst),
    .enable (count_white),
    .len    (cfg.white_len),
    .done   (white_done)
  );

  phase_timer black_timer (
    .clk    (clk),
    .rst    (rst),
    .enable (count_black),
    .len    (cfg.black_len),
    .done   (black_done)
  );

  frame_buffer fb (
    .clk     (clk),
    .wr      (wr),
    .rd_x    (rd_x),
    .rd_y    (rd_y),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// ==== hdl/frame_buffer.sv ====
`default_nettype none

module frame_buffer (
  input  logic                           clk,
  input  cursor_pkg::pixel_wr_t          wr,
  input  logic [cursor_pkg::coord_w-1:0] rd_x,
  input  logic [cursor_pkg::coord_w-1:0] rd_y,
  output logic [cursor_pkg::pixel_w-1:0] rd_data
);

  import cursor_pkg::*;

  logic [pixel_w-1:0] mem [fb_depth];

  logic [fb_addr_w-1:0] wr_addr;
  logic [fb_addr_w-1:0] rd_addr;

  // row major.
  assign wr_addr = {wr.y, wr.x};
  assign rd_addr = {rd_y, rd_x};

  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr_addr] <= wr.data;
    end
  end

  // read before write on a same-pixel collision.
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== hdl/phase_timer.sv ====
`default_nettype none

module phase_timer (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           enable,
  input  logic [cursor_pkg::phase_w-1:0] len,
  output logic                           done
);

  import cursor_pkg::*;

  logic [phase_w-1:0] count;

  // count restarts from zero on every new phase.
  always_ff @(posedge clk) begin
    if (rst || !enable) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // first enabled cycle sees count 0, so the phase is len+1 cycles.
  assign done = enable && (count == len);

endmodule

`default_nettype wire

// ==== cursor/cursor_control.sv ====
`default_nettype none

module cursor_control (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    init,
  input  cursor_pkg::cursor_cfg_t cfg,
  input  logic                    white_done,
  input  logic                    black_done,
  output logic                    count_white,
  output logic                    count_black,
  output cursor_pkg::pixel_wr_t   wr,
  output logic                    cursor_done
);

  import cursor_pkg::*;

  cursor_state_e state;

  // position held for the whole run.
  logic [coord_w-1:0] pos_x;
  logic [coord_w-1:0] pos_y;

  logic               wr_we;
  logic [pixel_w-1:0] wr_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_start;
    end else begin
      case (state)
        st_start: begin
          state <= init ? st_paint_white : st_start;
        end
        st_paint_white: begin
          state <= st_count_white;
        end
        st_count_white: begin
          state <= white_done ? st_paint_black : st_count_white;
        end
        st_paint_black: begin
          state <= st_count_black;
        end
        st_count_black: begin
          state <= black_done ? st_done : st_count_black;
        end
        st_done: begin
          state <= st_start;
        end
        default: begin
          state <= st_start;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_start) begin
      pos_x <= cfg.x;
      pos_y <= cfg.y;
    end
  end

  // pixel write and done pulse lag the state by one cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_we       <= 1'b0;
      cursor_done <= 1'b0;
    end else begin
      wr_we       <= (state == st_paint_white) || (state == st_paint_black);
      cursor_done <= (state == st_done);
    end
  end

  always_ff @(posedge clk) begin
    wr_data <= (state == st_paint_black) ? black_px : white_px;
  end

  assign count_white = (state == st_count_white);
  assign count_black = (state == st_count_black);

  assign wr = '{we: wr_we, x: pos_x, y: pos_y, data: wr_data};

endmodule

`default_nettype wire

// ==== cursor/cursor_regs.sv ====
`default_nettype none

module cursor_regs (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         cfg_we,
  input  cursor_pkg::cfg_addr_e        cfg_addr,
  input  logic [cursor_pkg::pixel_w-1:0] cfg_wdata,
  output cursor_pkg::cursor_cfg_t      cfg
);

  import cursor_pkg::*;

  // position fields only keep the low bits of the write data.
  logic [coord_w-1:0] wdata_coord;
  logic [phase_w-1:0] wdata_len;

  assign wdata_coord = cfg_wdata[coord_w-1:0];
  assign wdata_len   = cfg_wdata[phase_w-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg.x         <= '0;
      cfg.y         <= '0;
      cfg.white_len <= default_len;
      cfg.black_len <= default_len;
    end else if (cfg_we) begin
      case (cfg_addr)
        addr_x: begin
          cfg.x <= wdata_coord;
        end
        addr_y: begin
          cfg.y <= wdata_coord;
        end
        addr_white: begin
          cfg.white_len <= wdata_len;
        end
        addr_black: begin
          cfg.black_len <= wdata_len;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== common/cursor_pkg.sv ====
`default_nettype none

package cursor_pkg;

  // display geometry and pixel format.
  localparam int coord_w = 6;
  localparam int pixel_w = 8;
  localparam int phase_w = 8;

  localparam int fb_addr_w = 2 * coord_w;
  localparam int fb_depth  = 1 << fb_addr_w;

  // cursor colors.
  localparam logic [pixel_w-1:0] white_px = '1;
  localparam logic [pixel_w-1:0] black_px = '0;

  // phase length loaded by reset.
  localparam logic [phase_w-1:0] default_len = 8'd4;

  typedef enum logic [1:0] {
    addr_x     = 2'd0,
    addr_y     = 2'd1,
    addr_white = 2'd2,
    addr_black = 2'd3
  } cfg_addr_e;

  typedef enum logic [2:0] {
    st_start       = 3'b000,
    st_paint_white = 3'b001,
    st_count_white = 3'b010,
    st_paint_black = 3'b011,
    st_count_black = 3'b100,
    st_done        = 3'b101
  } cursor_state_e;

  typedef struct packed {
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
    logic [phase_w-1:0] white_len;
    logic [phase_w-1:0] black_len;
  } cursor_cfg_t;

  typedef struct packed {
    logic               we;
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
    logic [pixel_w-1:0] data;
  } pixel_wr_t;

endpackage

`default_nettype wire
